// ==== common/ixu_cfg.svh ====
`ifndef IXU_CFG_SVH
`define IXU_CFG_SVH

// Issue queue entries
`define IXU_IQ_DEPTH 4

// Physical integer registers, index 0 is hardwired to zero
`define IXU_PREGS 64

// Stimulus lines in the testbench data file
`define IXU_TB_DATA_LINES 30

// Run limit, two cycles per stimulus line plus drain margin
`define IXU_TB_MAX_CYCLES (`IXU_TB_DATA_LINES * 2 + 50)

`endif

// ==== common/ixu_pkg.sv ====
`include "ixu_cfg.svh"

package ixu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [$clog2(`IXU_PREGS)-1:0] preg_t;
  typedef logic [4:0] rob_t;
  // Byte address bits 31:2
  typedef logic [XLEN-3:0] pc_t;

  // Low bits follow funct3, bit 3 is funct7[5]
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    KIND_ALU    = 3'd0,
    KIND_LUI    = 3'd1,
    KIND_AUIPC  = 3'd2,
    KIND_JAL    = 3'd3,
    KIND_JALR   = 3'd4,
    KIND_BRANCH = 3'd5
  } ins_kind_e;

  // Branch funct3 encoding
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef struct packed {
    ins_kind_e kind;
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    preg_t     rs1;
    preg_t     rs2;
    preg_t     dest;
    rob_t      rob;
    logic      imm_sel;
    xlen_t     imm;
    pc_t       pc;
    logic      pred_taken;
    pc_t       pred_target;
  } uop_t;

  typedef struct packed {
    logic  valid;
    preg_t dest;
    xlen_t data;
    rob_t  rob;
  } wb_t;

  typedef struct packed {
    logic valid;
    rob_t rob;
    logic taken;
    pc_t  target;
    logic mispredict;
  } resolve_t;

endpackage

// ==== hw/ixu_issue_queue.sv ====
`include "ixu_cfg.svh"

module ixu_issue_queue (
  input  logic          core_clock_i,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          issue_stall_i,
  input  ixu_pkg::uop_t dispatch_uop_i,
  input  logic          dispatch_valid_i,
  output logic          dispatch_ready_o,
  output ixu_pkg::uop_t issue_uop_o,
  output logic          issue_valid_o
);
  import ixu_pkg::*;

  localparam int DEPTH = `IXU_IQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  uop_t entries [DEPTH];
  ptr_t rd_ptr;
  ptr_t wr_ptr;
  cnt_t count;
  logic push;
  logic pop;

  // Wrap explicitly so a depth that is not a power of two still works
  function automatic ptr_t ptr_next(ptr_t p);
    if (p == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign dispatch_ready_o = (count != cnt_t'(DEPTH));
  assign issue_valid_o    = (count != '0) && !issue_stall_i;
  assign issue_uop_o      = entries[rd_ptr];

  assign push = dispatch_valid_i && dispatch_ready_o;
  assign pop  = issue_valid_o;

  always_ff @(posedge core_clock_i) begin
    if (rst_i || flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge core_clock_i) begin
    if (push) begin
      entries[wr_ptr] <= dispatch_uop_i;
    end
  end

endmodule

// ==== hw/ixu_regfile.sv ====
`include "ixu_cfg.svh"

module ixu_regfile (
  input  logic           core_clock_i,
  input  ixu_pkg::preg_t rs1_i,
  input  ixu_pkg::preg_t rs2_i,
  output ixu_pkg::xlen_t rs1_data_o,
  output ixu_pkg::xlen_t rs2_data_o,
  input  ixu_pkg::wb_t   wb_i
);
  import ixu_pkg::*;

  xlen_t regs [`IXU_PREGS];
  logic  wr_en;

  assign wr_en = wb_i.valid && (wb_i.dest != '0);

  always_ff @(posedge core_clock_i) begin
    if (wr_en) begin
      regs[wb_i.dest] <= wb_i.data;
    end
  end

  // Same-cycle write is visible to the reader
  function automatic xlen_t read_port(preg_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wr_en && (wb_i.dest == idx)) begin
      return wb_i.data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

// ==== ixu_sc_pipe/ixu_alu.sv ====
module ixu_alu (
  input  ixu_pkg::xlen_t   a_i,
  input  ixu_pkg::xlen_t   b_i,
  input  ixu_pkg::alu_op_e op_i,
  output ixu_pkg::xlen_t   result_o,
  output logic             lt_signed_o,
  output logic             lt_unsigned_o,
  output logic             eq_o
);
  import ixu_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  // One extra bit keeps the borrow for the unsigned compare
  logic [XLEN:0]      diff;
  logic [SHAMT_W-1:0] shamt;

  assign diff  = {1'b0, a_i} - {1'b0, b_i};
  assign shamt = b_i[SHAMT_W-1:0];

  assign lt_unsigned_o = diff[XLEN];
  // Signs differ means a is smaller exactly when it is negative
  assign lt_signed_o   = (a_i[XLEN-1] != b_i[XLEN-1]) ? a_i[XLEN-1] : diff[XLEN-1];
  assign eq_o          = (a_i == b_i);

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = diff[XLEN-1:0];
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SLT: begin
        result_o = xlen_t'(lt_signed_o);
      end
      ALU_SLTU: begin
        result_o = xlen_t'(lt_unsigned_o);
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = xlen_t'($signed(a_i) >>> shamt);
      end
      default: begin
        result_o = a_i + b_i;
      end
    endcase
  end

endmodule

// ==== ixu_sc_pipe/ixu_branch_unit.sv ====
module ixu_branch_unit (
  input  ixu_pkg::ins_kind_e kind_i,
  input  ixu_pkg::br_cond_e  cond_i,
  input  logic               lt_signed_i,
  input  logic               lt_unsigned_i,
  input  logic               eq_i,
  input  ixu_pkg::xlen_t     rs1_i,
  input  ixu_pkg::xlen_t     offset_i,
  input  ixu_pkg::pc_t       pc_i,
  output logic               taken_o,
  output ixu_pkg::pc_t       target_o,
  output ixu_pkg::xlen_t     link_o
);
  import ixu_pkg::*;

  xlen_t pc_byte;
  xlen_t base;
  xlen_t target_byte;
  logic  cond_met;

  assign pc_byte     = {pc_i, 2'b00};
  assign base        = (kind_i == KIND_JALR) ? rs1_i : pc_byte;
  assign target_byte = base + offset_i;
  // Low two bits dropped, JALR bit 0 clear comes for free
  assign target_o    = target_byte[XLEN-1:2];

  // AUIPC shares the pc-relative adder
  assign link_o = (kind_i == KIND_AUIPC) ? target_byte : pc_byte + xlen_t'(4);

  always_comb begin
    case (cond_i)
      BR_EQ:   cond_met = eq_i;
      BR_NE:   cond_met = !eq_i;
      BR_LT:   cond_met = lt_signed_i;
      BR_GE:   cond_met = !lt_signed_i;
      BR_LTU:  cond_met = lt_unsigned_i;
      BR_GEU:  cond_met = !lt_unsigned_i;
      default: cond_met = 1'b0;
    endcase
  end

  always_comb begin
    case (kind_i)
      KIND_JAL,
      KIND_JALR:   taken_o = 1'b1;
      KIND_BRANCH: taken_o = cond_met;
      default:     taken_o = 1'b0;
    endcase
  end

endmodule

// ==== ixu_sc_pipe/ixu_sc_pipe.sv ====
module ixu_sc_pipe (
  input  logic              core_clock_i,
  input  logic              rst_i,
  input  logic              flush_i,
  input  ixu_pkg::uop_t     issue_uop_i,
  input  logic              issue_valid_i,
  output ixu_pkg::preg_t    rs1_o,
  output ixu_pkg::preg_t    rs2_o,
  input  ixu_pkg::xlen_t    rs1_data_i,
  input  ixu_pkg::xlen_t    rs2_data_i,
  output ixu_pkg::wb_t      wb_o,
  output ixu_pkg::resolve_t resolve_o
);
  import ixu_pkg::*;

  // Issue stage
  xlen_t   issue_a;
  xlen_t   issue_b;

  // Execute stage
  logic    ex_valid;
  uop_t    ex_uop;
  xlen_t   ex_a;
  xlen_t   ex_b;
  alu_op_e ex_op;
  xlen_t   alu_result;
  xlen_t   link;
  xlen_t   ex_result;
  logic    ex_writes;
  logic    ex_is_cf;
  logic    lt_signed;
  logic    lt_unsigned;
  logic    eq;
  logic    taken;
  pc_t     target;
  logic    mispredict;

  // Writeback stage
  logic    wb_valid;
  logic    res_valid;
  preg_t   wb_dest;
  xlen_t   wb_data;
  rob_t    wb_rob;
  logic    res_taken;
  pc_t     res_target;
  logic    res_mispredict;

  assign rs1_o = issue_uop_i.rs1;
  assign rs2_o = issue_uop_i.rs2;

  // Youngest producer wins, then WB, then the register file
  function automatic xlen_t forward(preg_t idx, xlen_t rf_data);
    if (ex_writes && (ex_uop.dest == idx)) begin
      return ex_result;
    end
    if (wb_valid && (wb_dest == idx)) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  always_comb begin
    issue_a = (issue_uop_i.kind == KIND_LUI) ? '0 : forward(issue_uop_i.rs1, rs1_data_i);
    if (issue_uop_i.imm_sel || (issue_uop_i.kind == KIND_LUI)) begin
      issue_b = issue_uop_i.imm;
    end else begin
      issue_b = forward(issue_uop_i.rs2, rs2_data_i);
    end
  end

  always_comb begin
    ex_op     = (ex_uop.kind == KIND_LUI) ? ALU_ADD : ex_uop.alu_op;
    ex_writes = ex_valid && (ex_uop.kind != KIND_BRANCH) && (ex_uop.dest != '0);
    ex_is_cf  = (ex_uop.kind == KIND_JAL) || (ex_uop.kind == KIND_JALR) ||
                (ex_uop.kind == KIND_BRANCH);
    if ((ex_uop.kind == KIND_ALU) || (ex_uop.kind == KIND_LUI)) begin
      ex_result = alu_result;
    end else begin
      ex_result = link;
    end
    mispredict = (taken != ex_uop.pred_taken) || (taken && (target != ex_uop.pred_target));
  end

  ixu_alu u_alu (
    .a_i          (ex_a),
    .b_i          (ex_b),
    .op_i         (ex_op),
    .result_o     (alu_result),
    .lt_signed_o  (lt_signed),
    .lt_unsigned_o(lt_unsigned),
    .eq_o         (eq)
  );

  ixu_branch_unit u_branch_unit (
    .kind_i       (ex_uop.kind),
    .cond_i       (ex_uop.br_cond),
    .lt_signed_i  (lt_signed),
    .lt_unsigned_i(lt_unsigned),
    .eq_i         (eq),
    .rs1_i        (ex_a),
    .offset_i     (ex_uop.imm),
    .pc_i         (ex_uop.pc),
    .taken_o      (taken),
    .target_o     (target),
    .link_o       (link)
  );

  always_ff @(posedge core_clock_i) begin
    if (rst_i || flush_i) begin
      ex_valid  <= 1'b0;
      wb_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      ex_valid  <= issue_valid_i;
      wb_valid  <= ex_writes;
      res_valid <= ex_valid && ex_is_cf;
    end
  end

  always_ff @(posedge core_clock_i) begin
    ex_uop         <= issue_uop_i;
    ex_a           <= issue_a;
    ex_b           <= issue_b;
    wb_dest        <= ex_uop.dest;
    wb_data        <= ex_result;
    wb_rob         <= ex_uop.rob;
    res_taken      <= taken;
    res_target     <= target;
    res_mispredict <= mispredict;
  end

  always_comb begin
    wb_o.valid           = wb_valid;
    wb_o.dest            = wb_dest;
    wb_o.data            = wb_data;
    wb_o.rob             = wb_rob;
    resolve_o.valid      = res_valid;
    resolve_o.rob        = wb_rob;
    resolve_o.taken      = res_taken;
    resolve_o.target     = res_target;
    resolve_o.mispredict = res_mispredict;
  end

endmodule

// ==== hw/ixu_top.sv ====
module ixu_top (
  input  logic              core_clock_i,
  input  logic              rst_i,
  input  logic              flush_i,
  input  logic              issue_stall_i,
  input  ixu_pkg::uop_t     dispatch_uop_i,
  input  logic              dispatch_valid_i,
  output logic              dispatch_ready_o,
  output ixu_pkg::wb_t      wb_o,
  output ixu_pkg::resolve_t resolve_o
);
  import ixu_pkg::*;

  uop_t  issue_uop;
  logic  issue_valid;
  preg_t rs1;
  preg_t rs2;
  xlen_t rs1_data;
  xlen_t rs2_data;

  ixu_issue_queue u_issue_queue (
    .core_clock_i    (core_clock_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .issue_stall_i   (issue_stall_i),
    .dispatch_uop_i  (dispatch_uop_i),
    .dispatch_valid_i(dispatch_valid_i),
    .dispatch_ready_o(dispatch_ready_o),
    .issue_uop_o     (issue_uop),
    .issue_valid_o   (issue_valid)
  );

  // Writeback result also feeds the register file write port
  ixu_regfile u_regfile (
    .core_clock_i(core_clock_i),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .wb_i        (wb_o)
  );

  ixu_sc_pipe u_sc_pipe (
    .core_clock_i (core_clock_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .issue_uop_i  (issue_uop),
    .issue_valid_i(issue_valid),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .wb_o         (wb_o),
    .resolve_o    (resolve_o)
  );

endmodule

// ==== verification/ixu_tb.sv ====
`include "ixu_cfg.svh"

module ixu_tb;
  import ixu_pkg::*;

  // Longest wait from a full queue to its last result, with margin
  localparam int DRAIN_CYCLES = `IXU_IQ_DEPTH + 4;

  logic     core_clock_i;
  logic     rst_i;
  logic     flush_i;
  logic     issue_stall_i;
  uop_t     dispatch_uop_i;
  logic     dispatch_valid_i;
  logic     dispatch_ready_o;
  wb_t      wb_o;
  resolve_t resolve_o;

  // Expected results in program order
  wb_t      wb_exp_q[$];
  resolve_t res_exp_q[$];
  int       cycle_count = 0;

  ixu_top uut (
    .core_clock_i    (core_clock_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .issue_stall_i   (issue_stall_i),
    .dispatch_uop_i  (dispatch_uop_i),
    .dispatch_valid_i(dispatch_valid_i),
    .dispatch_ready_o(dispatch_ready_o),
    .wb_o            (wb_o),
    .resolve_o       (resolve_o)
  );

  initial begin
    core_clock_i = 1'b0;
    forever #5 core_clock_i = ~core_clock_i;
  end

  always @(posedge core_clock_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= `IXU_TB_MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", `IXU_TB_MAX_CYCLES);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("ERROR time %0t %s got %h expected %h", $time, name, got, exp);
    $display("sim failed");
    $fatal(1, "result mismatch");
  endtask

  task automatic report_problem(string what);
    $display("At time %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_wb(wb_t got, wb_t exp);
    if (got.dest !== exp.dest) report_mismatch("wb_o.dest", 32'(got.dest), 32'(exp.dest));
    if (got.data !== exp.data) report_mismatch("wb_o.data", got.data, exp.data);
    if (got.rob !== exp.rob) report_mismatch("wb_o.rob", 32'(got.rob), 32'(exp.rob));
  endtask

  task automatic check_resolve(resolve_t got, resolve_t exp);
    if (got.rob !== exp.rob) begin
      report_mismatch("resolve_o.rob", 32'(got.rob), 32'(exp.rob));
    end
    if (got.taken !== exp.taken) begin
      report_mismatch("resolve_o.taken", 32'(got.taken), 32'(exp.taken));
    end
    if (got.target !== exp.target) begin
      report_mismatch("resolve_o.target", 32'(got.target), 32'(exp.target));
    end
    if (got.mispredict !== exp.mispredict) begin
      report_mismatch("resolve_o.mispredict", 32'(got.mispredict), 32'(exp.mispredict));
    end
  endtask

  task automatic check_ready(logic got, logic exp);
    if (got !== exp) report_mismatch("dispatch_ready_o", 32'(got), 32'(exp));
  endtask

  // Registered outputs have settled by the falling edge
  task automatic check_outputs;
    if (wb_o.valid === 1'b1) begin
      if (wb_exp_q.size() == 0) report_problem("wb_o is valid but no writeback was expected");
      check_wb(wb_o, wb_exp_q.pop_front());
    end
    if (resolve_o.valid === 1'b1) begin
      if (res_exp_q.size() == 0) report_problem("resolve_o is valid but no resolve was expected");
      check_resolve(resolve_o, res_exp_q.pop_front());
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          drain;
    string       line;
    logic [31:0] f[25];
    wb_t         wb_exp;
    resolve_t    res_exp;

    rst_i            = 1'b1;
    flush_i          = 1'b0;
    issue_stall_i    = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_uop_i   = '0;

    fd = $fopen("verification/ixu_testdata.txt", "r");
    if (fd == 0) report_problem("could not open the stimulus data file");

    repeat (2) @(posedge core_clock_i);
    @(negedge core_clock_i);
    rst_i = 1'b0;

    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                    f[19], f[20], f[21], f[22], f[23], f[24]);
        if (n != 25) report_problem("a stimulus line does not have 25 columns");
        check_outputs();
        check_ready(dispatch_ready_o, f[15][0]);

        dispatch_valid_i           = f[0][0];
        dispatch_uop_i.kind        = ins_kind_e'(f[1][2:0]);
        dispatch_uop_i.alu_op      = alu_op_e'(f[2][3:0]);
        dispatch_uop_i.br_cond     = br_cond_e'(f[3][2:0]);
        dispatch_uop_i.rs1         = preg_t'(f[4]);
        dispatch_uop_i.rs2         = preg_t'(f[5]);
        dispatch_uop_i.dest        = preg_t'(f[6]);
        dispatch_uop_i.rob         = rob_t'(f[7]);
        dispatch_uop_i.imm_sel     = f[8][0];
        dispatch_uop_i.imm         = f[9];
        dispatch_uop_i.pc          = pc_t'(f[10]);
        dispatch_uop_i.pred_taken  = f[11][0];
        dispatch_uop_i.pred_target = pc_t'(f[12]);
        issue_stall_i              = f[13][0];
        flush_i                    = f[14][0];

        if (f[16][0]) begin
          wb_exp.valid = 1'b1;
          wb_exp.dest  = preg_t'(f[17]);
          wb_exp.data  = f[18];
          wb_exp.rob   = rob_t'(f[19]);
          wb_exp_q.push_back(wb_exp);
        end
        if (f[20][0]) begin
          res_exp.valid      = 1'b1;
          res_exp.rob        = rob_t'(f[21]);
          res_exp.taken      = f[22][0];
          res_exp.target     = pc_t'(f[23]);
          res_exp.mispredict = f[24][0];
          res_exp_q.push_back(res_exp);
        end
        @(negedge core_clock_i);
      end
    end
    $fclose(fd);

    dispatch_valid_i = 1'b0;
    issue_stall_i    = 1'b0;
    flush_i          = 1'b0;

    drain = 0;
    while ((wb_exp_q.size() != 0 || res_exp_q.size() != 0) && drain < DRAIN_CYCLES) begin
      check_outputs();
      drain++;
      @(negedge core_clock_i);
    end
    // A few idle cycles catch results that should never appear
    repeat (4) begin
      check_outputs();
      @(negedge core_clock_i);
    end

    if (wb_exp_q.size() != 0 || res_exp_q.size() != 0) begin
      $display("Expected results were never produced by the DUT");
      $display("sim failed");
      $fatal(1, "missing results");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== biriq_ixu.f ====
+incdir+common
common/ixu_pkg.sv
hw/ixu_issue_queue.sv
hw/ixu_regfile.sv
ixu_sc_pipe/ixu_alu.sv
ixu_sc_pipe/ixu_branch_unit.sv
ixu_sc_pipe/ixu_sc_pipe.sv
hw/ixu_top.sv
verification/ixu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f biriq_ixu.f --top-module ixu_tb -o ixu_sim

output=$(./obj_dir/ixu_sim) || true
echo "$output"

if echo "$output" | grep -q "^sim passed$"; then
  exit 0
else
  exit 1
fi

// ==== verification/ixu_testdata.txt ====
# v kind op cond rs1 rs2 dest rob isel imm pc ptaken ptarget stall flush ready (all hex)
# then wb: valid dest data rob, then resolve: valid rob taken target mispredict
1 1 0 0 00 00 01 01 1 80000000 40 0 00 0 0 1  1 01 80000000 01  0 00 0 00 0
1 1 0 0 00 00 02 02 1 00000005 40 0 00 0 0 1  1 02 00000005 02  0 00 0 00 0
1 0 0 0 01 02 03 03 0 00000000 40 0 00 0 0 1  1 03 80000005 03  0 00 0 00 0
1 0 8 0 02 01 04 04 0 00000000 40 0 00 0 0 1  1 04 80000005 04  0 00 0 00 0
1 0 2 0 01 02 05 05 0 00000000 40 0 00 0 0 1  1 05 00000001 05  0 00 0 00 0
1 0 3 0 01 00 06 06 1 00000005 40 0 00 0 0 1  1 06 00000000 06  0 00 0 00 0
1 0 d 0 01 00 07 07 1 00000004 40 0 00 0 0 1  1 07 f8000000 07  0 00 0 00 0
1 0 5 0 01 02 08 08 0 00000000 40 0 00 0 0 1  1 08 04000000 08  0 00 0 00 0
1 0 1 0 02 00 09 09 1 00000003 40 0 00 0 0 1  1 09 00000028 09  0 00 0 00 0
1 0 4 0 02 00 0a 0a 1 000000ff 40 0 00 0 0 1  1 0a 000000fa 0a  0 00 0 00 0
1 0 6 0 01 02 0b 0b 0 00000000 40 0 00 0 0 1  1 0b 80000005 0b  0 00 0 00 0
1 0 7 0 03 00 00 0c 1 0000000f 40 0 00 0 0 1  0 00 00000000 00  0 00 0 00 0
1 0 0 0 00 02 0c 0d 0 00000000 40 0 00 0 0 1  1 0c 00000005 0d  0 00 0 00 0
1 5 0 0 02 0c 00 0e 0 00000010 40 1 44 0 0 1  0 00 00000000 00  1 0e 1 44 0
1 5 0 1 02 0c 00 0f 0 00000010 40 1 44 0 0 1  0 00 00000000 00  1 0f 0 44 1
1 5 0 4 01 02 00 10 0 00000010 40 0 00 0 0 1  0 00 00000000 00  1 10 1 44 1
1 5 0 7 01 02 00 11 0 00000010 40 1 50 0 0 1  0 00 00000000 00  1 11 1 44 1
1 3 0 0 00 00 0d 12 1 00000020 40 1 48 0 0 1  1 0d 00000104 12  1 12 1 48 0
1 4 0 0 0d 00 0e 13 1 00000008 40 1 48 0 0 1  1 0e 00000104 13  1 13 1 43 1
1 2 0 0 00 00 0f 14 1 00001000 40 0 00 0 0 1  1 0f 00001100 14  0 00 0 00 0
1 0 0 0 02 00 10 15 1 00000001 40 0 00 1 0 1  1 10 00000006 15  0 00 0 00 0
1 0 0 0 10 00 11 16 1 00000001 40 0 00 1 0 1  0 00 00000000 00  0 00 0 00 0
1 0 0 0 11 00 12 17 1 00000001 40 0 00 1 0 1  0 00 00000000 00  0 00 0 00 0
1 0 0 0 02 00 13 18 1 00000001 40 0 00 1 0 0  0 00 00000000 00  0 00 0 00 0
0 0 0 0 00 00 00 00 0 00000000 40 0 00 0 0 0  0 00 00000000 00  0 00 0 00 0
1 0 0 0 12 02 13 19 0 00000000 40 0 00 0 0 1  0 00 00000000 00  0 00 0 00 0
1 0 0 0 02 00 14 1a 1 00000100 40 0 00 0 0 1  0 00 00000000 00  0 00 0 00 0
0 0 0 0 00 00 00 00 0 00000000 40 0 00 0 1 1  0 00 00000000 00  0 00 0 00 0
1 0 0 0 10 02 15 1c 0 00000000 40 0 00 0 0 1  1 15 0000000b 1c  0 00 0 00 0
1 0 0 0 15 00 16 1d 1 00000001 40 0 00 0 0 1  1 16 0000000c 1d  0 00 0 00 0
